// File: Makefile
# Verilator build and run of the board-control testbench

SIM := obj_dir/Vtb_board_ctrl

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --top-module tb_board_ctrl -f files.f
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

// File: files.f
+incdir+test
source/board_pkg.sv
source/video_pkg.sv
source/input_sync.sv
source/backlight_timer.sv
source/lock_warning.sv
source/osd_overlay.sv
source/board_ctrl_top.sv
test/tb_board_ctrl.sv

// File: source/backlight_timer.sv
/*
 * LCD backlight timeout. Counts milliseconds since the last remote event
 * and turns the backlight off after the threshold picked by bl_time_i.
 * CLK_PER_MS is the number of clk27 cycles in one millisecond.
 */
module backlight_timer import board_pkg::*; #(
    parameter int CLK_PER_MS = 27000
) (
    input  logic       clk27,
    input  logic       po_reset_n,
    input  logic       remote_event_i,
    input  logic       bl_on_i,
    input  logic [1:0] bl_time_i,
    output logic       lcd_bl_o
);

    localparam int PRE_W = (CLK_PER_MS > 1) ? $clog2(CLK_PER_MS) : 1;

    logic                remote_prev;
    logic                event_seen;
    logic [PRE_W-1:0]    pre_cnt;
    logic [MS_CNT_W-1:0] ms_cnt;
    logic [MS_CNT_W-1:0] threshold;
    logic                bl_timeout;

    // Any change of the event bit means the remote was used
    assign event_seen = (remote_event_i != remote_prev);

    always_ff @(posedge clk27 or negedge po_reset_n) begin
        if (!po_reset_n) begin
            remote_prev <= 1'b0;
            pre_cnt     <= '0;
            ms_cnt      <= '0;
        end else begin
            remote_prev <= remote_event_i;
            if (event_seen) begin
                pre_cnt <= '0;
                ms_cnt  <= '0;
            end else if (pre_cnt == PRE_W'(CLK_PER_MS - 1)) begin
                pre_cnt <= '0;
                if (ms_cnt != '1)
                    ms_cnt <= ms_cnt + 1'b1;
            end else begin
                pre_cnt <= pre_cnt + 1'b1;
            end
        end
    end

    // Select 0 disables the timeout
    always_comb begin
        case (bl_time_i)
            2'd1:    threshold = BL_3S_MS;
            2'd2:    threshold = BL_10S_MS;
            2'd3:    threshold = BL_30S_MS;
            default: threshold = '0;
        endcase
    end

    always_ff @(posedge clk27 or negedge po_reset_n) begin
        if (!po_reset_n)
            bl_timeout <= 1'b0;
        else
            bl_timeout <= (bl_time_i != 2'd0) && (ms_cnt >= threshold);
    end

    assign lcd_bl_o = bl_on_i & ~bl_timeout;

    a_pre_range: assert property (@(posedge clk27) disable iff (!po_reset_n)
        int'(pre_cnt) < CLK_PER_MS);

    // Count only moves down when a remote event clears it
    a_ms_monotonic: assert property (@(posedge clk27) disable iff (!po_reset_n)
        !event_seen |=> (ms_cnt >= $past(ms_cnt)));

endmodule

// File: source/board_ctrl_top.sv
/*
 * Board-control top level. Splits the CPU system-control word into pins
 * and block controls, and ties together input sync, backlight timer,
 * lock warning and the HDMI output stage.
 */
module board_ctrl_top import board_pkg::*, video_pkg::*; #(
    parameter int CLK_PER_MS    = 27000,
    parameter int RESYNC_HOLD_W = 24
) (
    input  logic                   clk27,
    input  logic                   po_reset_n,
    input  logic [CTRL_W-1:0]      sys_ctrl_i,
    // Board inputs
    input  logic [1:0]             btn_i,
    input  logic [1:0]             cfg_i,
    input  logic                   vsync_sc_i,
    // IR receiver results
    input  logic [IR_CODE_W-1:0]   ir_code_i,
    input  logic [IR_CNT_W-1:0]    ir_code_cnt_i,
    // Scaler and PLL status
    input  logic                   resync_strobe_i,
    input  logic                   pll_areset_i,
    input  logic                   pll_locked_i,
    input  logic                   pll_activeclock_i,
    // Scaled video and OSD
    input  logic [PIX_W-1:0]       r_i,
    input  logic [PIX_W-1:0]       g_i,
    input  logic [PIX_W-1:0]       b_i,
    input  logic                   de_i,
    input  logic                   hs_i,
    input  logic                   vs_i,
    input  logic                   osd_enable_i,
    input  logic [OSD_COLOR_W-1:0] osd_color_i,
    output logic [CTRL_W-1:0]      controls_o,
    output logic                   hw_reset_n_o,
    output logic                   lcd_cs_n_o,
    output logic                   lcd_rs_o,
    output logic                   sd_ss_n_o,
    output logic                   lcd_bl_o,
    output logic                   led_r_o,
    output logic                   led_g_o,
    output logic                   led_r_oe_o,
    output logic                   pll_clkswitch_o,
    output logic [3*PIX_W-1:0]     hdmi_rgb_o,
    output logic                   hdmi_de_o,
    output logic                   hdmi_hs_o,
    output logic                   hdmi_vs_o
);

    logic       remote_event;
    logic       bl_on;
    logic [1:0] bl_time;
    logic       enable_sc;
    logic [1:0] cfg;

    assign remote_event = sys_ctrl_i[CTRL_REMOTE_EVENT_BIT];
    assign bl_on        = sys_ctrl_i[CTRL_BL_ON_BIT];
    assign bl_time      = sys_ctrl_i[CTRL_BL_TIME_LSB +: 2];
    assign enable_sc    = sys_ctrl_i[CTRL_ENABLE_SC_BIT];

    // Direct pins
    assign sd_ss_n_o    = sys_ctrl_i[CTRL_SD_SS_N_BIT];
    assign lcd_cs_n_o   = sys_ctrl_i[CTRL_LCD_CS_N_BIT];
    assign lcd_rs_o     = sys_ctrl_i[CTRL_LCD_RS_BIT];
    assign hw_reset_n_o = sys_ctrl_i[CTRL_HW_RESET_N_BIT];

    // Jumper 1 drives the output enable of the red LED pin
    assign led_r_oe_o = cfg[1];

    // Buttons reach the CPU only through the status word
    input_sync u_input_sync (
        .clk27             (clk27),
        .po_reset_n        (po_reset_n),
        .btn_i             (btn_i),
        .cfg_i             (cfg_i),
        .vsync_sc_i        (vsync_sc_i),
        .ir_code_i         (ir_code_i),
        .ir_code_cnt_i     (ir_code_cnt_i),
        .pll_activeclock_i (pll_activeclock_i),
        .controls_o        (controls_o),
        .btn_sync_o        (),
        .cfg_o             (cfg)
    );

    backlight_timer #(
        .CLK_PER_MS (CLK_PER_MS)
    ) u_backlight_timer (
        .clk27          (clk27),
        .po_reset_n     (po_reset_n),
        .remote_event_i (remote_event),
        .bl_on_i        (bl_on),
        .bl_time_i      (bl_time),
        .lcd_bl_o       (lcd_bl_o)
    );

    lock_warning #(
        .RESYNC_HOLD_W (RESYNC_HOLD_W)
    ) u_lock_warning (
        .clk27             (clk27),
        .po_reset_n        (po_reset_n),
        .resync_strobe_i   (resync_strobe_i),
        .enable_sc_i       (enable_sc),
        .pll_areset_i      (pll_areset_i),
        .pll_locked_i      (pll_locked_i),
        .pll_activeclock_i (pll_activeclock_i),
        .ir_code_i         (ir_code_i),
        .cfg_alt_i         (cfg[1]),
        .led_r_o           (led_r_o),
        .led_g_o           (led_g_o),
        .pll_clkswitch_o   (pll_clkswitch_o)
    );

    osd_overlay u_osd_overlay (
        .clk27        (clk27),
        .po_reset_n   (po_reset_n),
        .r_i          (r_i),
        .g_i          (g_i),
        .b_i          (b_i),
        .de_i         (de_i),
        .hs_i         (hs_i),
        .vs_i         (vs_i),
        .osd_enable_i (osd_enable_i),
        .osd_color_i  (osd_color_i),
        .hdmi_rgb_o   (hdmi_rgb_o),
        .hdmi_de_o    (hdmi_de_o),
        .hdmi_hs_o    (hdmi_hs_o),
        .hdmi_vs_o    (hdmi_vs_o)
    );

endmodule

// File: source/board_pkg.sv
/*
 * Board-level constants shared by the clk27 control glue.
 * Bit positions of the CPU system-control word, layout of the status word
 * read back by the CPU, and the LCD backlight timeout thresholds.
 */
package board_pkg;

    // Control and status words are both one CPU register wide
    localparam int CTRL_W = 32;

    localparam int IR_CODE_W = 16;
    localparam int IR_CNT_W  = 8;

    // System-control word written by the CPU
    localparam int CTRL_HW_RESET_N_BIT   = 0;
    localparam int CTRL_ENABLE_SC_BIT    = 1;
    // Two-bit backlight timeout select
    localparam int CTRL_BL_TIME_LSB      = 2;
    localparam int CTRL_BL_ON_BIT        = 4;
    localparam int CTRL_LCD_RS_BIT       = 5;
    localparam int CTRL_LCD_CS_N_BIT     = 6;
    localparam int CTRL_SD_SS_N_BIT      = 7;
    localparam int CTRL_REMOTE_EVENT_BIT = 8;

    // Status word, bits 23..21 read as zero
    localparam int STAT_IR_CODE_LSB   = 0;
    localparam int STAT_BTN_LSB       = 16;
    localparam int STAT_CFG0_BIT      = 18;
    localparam int STAT_ACTIVECLK_BIT = 19;
    localparam int STAT_VSYNC_BIT     = 20;
    localparam int STAT_IR_CNT_LSB    = 24;

    // Millisecond counter saturates at all ones
    localparam int MS_CNT_W = 15;

    localparam logic [MS_CNT_W-1:0] BL_3S_MS  = 15'd3000;
    localparam logic [MS_CNT_W-1:0] BL_10S_MS = 15'd10000;
    localparam logic [MS_CNT_W-1:0] BL_30S_MS = 15'd30000;

endpackage

// File: source/input_sync.sv
/*
 * Brings the buttons and the scaler vsync flag into clk27, latches the
 * configuration jumpers once after reset and builds the status word
 * that the CPU polls.
 */
module input_sync import board_pkg::*; (
    input  logic                 clk27,
    input  logic                 po_reset_n,
    input  logic [1:0]           btn_i,
    input  logic [1:0]           cfg_i,
    input  logic                 vsync_sc_i,
    input  logic [IR_CODE_W-1:0] ir_code_i,
    input  logic [IR_CNT_W-1:0]  ir_code_cnt_i,
    input  logic                 pll_activeclock_i,
    output logic [CTRL_W-1:0]    controls_o,
    output logic [1:0]           btn_sync_o,
    output logic [1:0]           cfg_o
);

    logic [1:0] btn_meta;
    logic [1:0] btn_sync;
    logic       vsync_meta;
    logic       vsync_sync;
    logic [1:0] cfg_reg;
    logic       cfg_stored;

    always_ff @(posedge clk27 or negedge po_reset_n) begin
        if (!po_reset_n) begin
            btn_meta   <= '0;
            btn_sync   <= '0;
            vsync_meta <= 1'b0;
            vsync_sync <= 1'b0;
            cfg_reg    <= '0;
            cfg_stored <= 1'b0;
        end else begin
            btn_meta   <= btn_i;
            btn_sync   <= btn_meta;
            // Flag is reported active high to the CPU
            vsync_meta <= ~vsync_sc_i;
            vsync_sync <= vsync_meta;
            // Jumpers are sampled on the first clock only
            if (!cfg_stored)
                cfg_reg <= cfg_i;
            cfg_stored <= 1'b1;
        end
    end

    always_comb begin
        controls_o = '0;
        controls_o[STAT_IR_CODE_LSB +: IR_CODE_W] = ir_code_i;
        controls_o[STAT_BTN_LSB +: 2]             = btn_sync;
        controls_o[STAT_CFG0_BIT]                 = cfg_reg[0];
        controls_o[STAT_ACTIVECLK_BIT]            = pll_activeclock_i;
        controls_o[STAT_VSYNC_BIT]                = vsync_sync;
        controls_o[STAT_IR_CNT_LSB +: IR_CNT_W]   = ir_code_cnt_i;
    end

    assign btn_sync_o = btn_sync;
    assign cfg_o      = cfg_reg;

    // Jumper value is frozen for the whole run once captured
    a_cfg_frozen: assert property (@(posedge clk27) disable iff (!po_reset_n)
        cfg_stored |=> $stable(cfg_reg));

endmodule

// File: source/lock_warning.sv
/*
 * Warning LED for scaler resyncs and PLL lock loss, the green status LED
 * and the PLL reference clock-switch request. Each warning is held for
 * roughly 2^RESYNC_HOLD_W clk27 cycles.
 */
module lock_warning import board_pkg::*; #(
    parameter int RESYNC_HOLD_W = 24
) (
    input  logic                 clk27,
    input  logic                 po_reset_n,
    input  logic                 resync_strobe_i,
    input  logic                 enable_sc_i,
    input  logic                 pll_areset_i,
    input  logic                 pll_locked_i,
    input  logic                 pll_activeclock_i,
    input  logic [IR_CODE_W-1:0] ir_code_i,
    input  logic                 cfg_alt_i,
    output logic                 led_r_o,
    output logic                 led_g_o,
    output logic                 pll_clkswitch_o
);

    logic                     strobe_meta;
    logic                     strobe_sync;
    logic                     strobe_prev;
    logic                     strobe_rise;
    logic [RESYNC_HOLD_W-1:0] resync_ctr;
    logic [RESYNC_HOLD_W-1:0] pll_warn_ctr;
    logic                     clkswitch_q;
    logic                     warn;

    // Strobe comes from the scaler clock domain
    always_ff @(posedge clk27 or negedge po_reset_n) begin
        if (!po_reset_n) begin
            strobe_meta <= 1'b0;
            strobe_sync <= 1'b0;
            strobe_prev <= 1'b0;
        end else begin
            strobe_meta <= resync_strobe_i;
            strobe_sync <= strobe_meta;
            strobe_prev <= strobe_sync;
        end
    end

    assign strobe_rise = strobe_sync & ~strobe_prev;

    // Resync hold counter, frozen while the scaler is disabled
    always_ff @(posedge clk27 or negedge po_reset_n) begin
        if (!po_reset_n) begin
            resync_ctr <= '0;
        end else if (enable_sc_i) begin
            if (strobe_rise)
                resync_ctr <= '1;
            else if (resync_ctr != '0)
                resync_ctr <= resync_ctr - 1'b1;
        end
    end

    // Lock loss restarts the count at 1, it then runs up until it wraps
    always_ff @(posedge clk27 or negedge po_reset_n) begin
        if (!po_reset_n)
            pll_warn_ctr <= '0;
        else if (!pll_areset_i && !pll_locked_i)
            pll_warn_ctr <= RESYNC_HOLD_W'(1);
        else if (pll_warn_ctr != '0)
            pll_warn_ctr <= pll_warn_ctr + 1'b1;
    end

    // Request a switch when the active reference is not the wanted one
    always_ff @(posedge clk27 or negedge po_reset_n) begin
        if (!po_reset_n)
            clkswitch_q <= 1'b0;
        else
            clkswitch_q <= (pll_activeclock_i != enable_sc_i);
    end

    assign warn            = (resync_ctr != '0) | (pll_warn_ctr != '0);
    assign led_r_o         = warn;
    assign led_g_o         = (ir_code_i == '0) & (~warn | cfg_alt_i);
    assign pll_clkswitch_o = clkswitch_q;

    a_no_reload_when_off: assert property (@(posedge clk27) disable iff (!po_reset_n)
        !enable_sc_i |=> !((resync_ctr == '1) && ($past(resync_ctr) != '1)));

endmodule

// File: source/osd_overlay.sv
/*
 * HDMI transmitter output registers. Video and sync pass through with one
 * cycle of delay; while the OSD is active its palette colour replaces
 * the pixel.
 */
module osd_overlay import video_pkg::*; (
    input  logic                   clk27,
    input  logic                   po_reset_n,
    input  logic [PIX_W-1:0]       r_i,
    input  logic [PIX_W-1:0]       g_i,
    input  logic [PIX_W-1:0]       b_i,
    input  logic                   de_i,
    input  logic                   hs_i,
    input  logic                   vs_i,
    input  logic                   osd_enable_i,
    input  logic [OSD_COLOR_W-1:0] osd_color_i,
    output logic [3*PIX_W-1:0]     hdmi_rgb_o,
    output logic                   hdmi_de_o,
    output logic                   hdmi_hs_o,
    output logic                   hdmi_vs_o
);

    logic [3*PIX_W-1:0] osd_rgb;

    always_comb begin
        case (osd_color_i)
            2'd0:    osd_rgb = OSD_PAL_0;
            2'd1:    osd_rgb = OSD_PAL_1;
            2'd2:    osd_rgb = OSD_PAL_2;
            default: osd_rgb = OSD_PAL_3;
        endcase
    end

    always_ff @(posedge clk27 or negedge po_reset_n) begin
        if (!po_reset_n) begin
            hdmi_rgb_o <= '0;
            hdmi_de_o  <= 1'b0;
            hdmi_hs_o  <= 1'b0;
            hdmi_vs_o  <= 1'b0;
        end else begin
            hdmi_rgb_o <= osd_enable_i ? osd_rgb : {r_i, g_i, b_i};
            hdmi_de_o  <= de_i;
            hdmi_hs_o  <= hs_i;
            hdmi_vs_o  <= vs_i;
        end
    end

    a_out_known: assert property (@(posedge clk27) disable iff (!po_reset_n)
        !$isunknown({hdmi_rgb_o, hdmi_de_o, hdmi_hs_o, hdmi_vs_o}));

endmodule

// File: source/video_pkg.sv
/*
 * Video output constants: colour channel width and the OSD palette.
 * The palette entries are packed as {R, G, B}, one PIX_W field each.
 */
package video_pkg;

    // One colour channel
    localparam int PIX_W = 8;

    // OSD colour index width, four palette entries
    localparam int OSD_COLOR_W = 2;

    // Black
    localparam logic [3*PIX_W-1:0] OSD_PAL_0 = 24'h000000;

    // Blue
    localparam logic [3*PIX_W-1:0] OSD_PAL_1 = 24'h0000ff;

    // Yellow
    localparam logic [3*PIX_W-1:0] OSD_PAL_2 = 24'hffff00;

    // White
    localparam logic [3*PIX_W-1:0] OSD_PAL_3 = 24'hffffff;

endpackage

// File: test/tb_vectors.svh
/*
 * Stimulus and expected values for the OSD and status-word checks.
 * Included inside the testbench module. Pixel values are drawn at run time.
 */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Columns: OSD enable, colour index, DE, HS, VS, expected RGB while the OSD is on
typedef struct packed {
    logic        osd_en;
    logic [1:0]  color;
    logic        de;
    logic        hs;
    logic        vs;
    logic [23:0] exp_rgb;
} osd_vec_t;

localparam int NUM_OSD = 8;
localparam osd_vec_t OSD_VECS [NUM_OSD] = '{
    '{1'b0, 2'd0, 1'b1, 1'b0, 1'b0, 24'h000000},
    '{1'b1, 2'd0, 1'b1, 1'b0, 1'b0, 24'h000000},
    '{1'b1, 2'd1, 1'b1, 1'b1, 1'b0, 24'h0000ff},
    '{1'b0, 2'd2, 1'b1, 1'b1, 1'b0, 24'h000000},
    '{1'b1, 2'd2, 1'b0, 1'b0, 1'b1, 24'hffff00},
    '{1'b1, 2'd3, 1'b0, 1'b1, 1'b1, 24'hffffff},
    '{1'b0, 2'd3, 1'b0, 1'b1, 1'b1, 24'h000000},
    '{1'b1, 2'd1, 1'b0, 1'b0, 1'b1, 24'h0000ff}
};

// Columns: buttons, raw vsync, IR code, IR count, active clock, expected status word
// Expected words assume jumper 0 high and jumper 1 low at reset
typedef struct packed {
    logic [1:0]  btn;
    logic        vsync;
    logic [15:0] ir_code;
    logic [7:0]  ir_cnt;
    logic        actclk;
    logic [31:0] exp_word;
} stat_vec_t;

localparam int NUM_STAT = 5;
localparam stat_vec_t STAT_VECS [NUM_STAT] = '{
    '{2'b00, 1'b1, 16'h0000, 8'h00, 1'b0, 32'h0004_0000},
    '{2'b01, 1'b0, 16'h1234, 8'h05, 1'b0, 32'h0515_1234},
    '{2'b10, 1'b1, 16'habcd, 8'hff, 1'b1, 32'hff0e_abcd},
    '{2'b11, 1'b0, 16'h8001, 8'h3c, 1'b1, 32'h3c1f_8001},
    '{2'b01, 1'b1, 16'h0000, 8'h00, 1'b1, 32'h000d_0000}
};

`endif

// File: test/tb_board_ctrl.sv
/*
 * Testbench for the board-control top level. Runs the OSD, status word,
 * jumper latch, control pin, warning LED, clock-switch and backlight
 * scenarios with short timing parameters, then prints a summary.
 */
module tb_board_ctrl import board_pkg::*, video_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    // 4 cycles per millisecond and a 63-cycle warning hold
    localparam int CLK_PER_MS = 4;
    localparam int HOLD_W     = 6;

    `include "tb_vectors.svh"

    // Backlight time in ms: 3 s window, restart, select 0 run, 10 s and 30 s windows
    localparam int BL_MS       = 3100 + 2000 + 3100 + 3200 + 10100 + 30100;
    localparam int TIMEOUT_CYC = 8 + 2 * NUM_OSD + 4 * NUM_STAT + 500
                                 + BL_MS * CLK_PER_MS + 2000;

    logic                   clk27, po_reset_n;
    logic [CTRL_W-1:0]      sys_ctrl_i;
    logic [1:0]             btn_i, cfg_i;
    logic                   vsync_sc_i;
    logic [IR_CODE_W-1:0]   ir_code_i;
    logic [IR_CNT_W-1:0]    ir_code_cnt_i;
    logic                   resync_strobe_i, pll_areset_i, pll_locked_i, pll_activeclock_i;
    logic [PIX_W-1:0]       r_i, g_i, b_i;
    logic                   de_i, hs_i, vs_i, osd_enable_i;
    logic [OSD_COLOR_W-1:0] osd_color_i;
    logic [CTRL_W-1:0]      controls_o;
    logic                   hw_reset_n_o, lcd_cs_n_o, lcd_rs_o, sd_ss_n_o, lcd_bl_o;
    logic                   led_r_o, led_g_o, led_r_oe_o, pll_clkswitch_o;
    logic [3*PIX_W-1:0]     hdmi_rgb_o;
    logic                   hdmi_de_o, hdmi_hs_o, hdmi_vs_o;

    integer seed;
    int     check_count, error_count, checks_at_start, errors_at_start;
    int     cycle_count;

    board_ctrl_top #(
        .CLK_PER_MS    (CLK_PER_MS),
        .RESYNC_HOLD_W (HOLD_W)
    ) dut (.*);

    initial begin
        clk27 = 1'b0;
        forever #20 clk27 = ~clk27;
    end

    // Advance n rising edges, then to the drive point just after the edge
    task automatic step(input int n);
        repeat (n) @(posedge clk27);
        #2;
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] want,
                               input string what);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("[ERROR] t=%0t: %s, got %0h, expected %0h", $time, what, got, want);
        end
    endtask

    task automatic report_test(input string name);
        $display("%s finished: %0d checks, %0d failed", name,
                 check_count - checks_at_start, error_count - errors_at_start);
        checks_at_start = check_count;
        errors_at_start = error_count;
    endtask

    // Samples at falling edges until the LED reaches the level or max_cyc runs out
    task automatic wait_for_led_r(input logic level, input int max_cyc, output int waited);
        waited = 0;
        @(negedge clk27);
        while (led_r_o !== level && waited < max_cyc) begin
            @(negedge clk27);
            waited++;
        end
    endtask

    task automatic toggle_remote();
        sys_ctrl_i[CTRL_REMOTE_EVENT_BIT] = ~sys_ctrl_i[CTRL_REMOTE_EVENT_BIT];
    endtask

    task automatic osd_overlay_test();
        logic [31:0] pix;
        logic [23:0] want_rgb;
        logic [23:0] prev_rgb;
        logic [2:0]  prev_sync;
        // Outputs hold the idle inputs from reset
        prev_rgb  = '0;
        prev_sync = 3'b000;
        for (int i = 0; i < NUM_OSD; i++) begin
            pix          = $random(seed);
            {r_i, g_i, b_i} = pix[23:0];
            osd_enable_i = OSD_VECS[i].osd_en;
            osd_color_i  = OSD_VECS[i].color;
            {de_i, hs_i, vs_i} = {OSD_VECS[i].de, OSD_VECS[i].hs, OSD_VECS[i].vs};
            want_rgb     = OSD_VECS[i].osd_en ? OSD_VECS[i].exp_rgb : pix[23:0];
            @(negedge clk27);
            check_equal(32'(hdmi_rgb_o), 32'(prev_rgb),
                        $sformatf("osd row %0d rgb before edge", i));
            check_equal(32'({hdmi_de_o, hdmi_hs_o, hdmi_vs_o}), 32'(prev_sync),
                        $sformatf("osd row %0d sync before edge", i));
            step(1);
            @(negedge clk27);
            check_equal(32'(hdmi_rgb_o), 32'(want_rgb), $sformatf("osd row %0d rgb", i));
            check_equal(32'({hdmi_de_o, hdmi_hs_o, hdmi_vs_o}),
                        32'({OSD_VECS[i].de, OSD_VECS[i].hs, OSD_VECS[i].vs}),
                        $sformatf("osd row %0d sync", i));
            prev_rgb  = want_rgb;
            prev_sync = {OSD_VECS[i].de, OSD_VECS[i].hs, OSD_VECS[i].vs};
            step(1);
        end
        osd_enable_i = 1'b0;
        report_test("osd overlay");
    endtask

    task automatic status_word_test();
        for (int i = 0; i < NUM_STAT; i++) begin
            btn_i             = STAT_VECS[i].btn;
            vsync_sc_i        = STAT_VECS[i].vsync;
            ir_code_i         = STAT_VECS[i].ir_code;
            ir_code_cnt_i     = STAT_VECS[i].ir_cnt;
            pll_activeclock_i = STAT_VECS[i].actclk;
            step(3);
            @(negedge clk27);
            check_equal(controls_o, STAT_VECS[i].exp_word, $sformatf("status row %0d", i));
            step(1);
        end
        btn_i             = 2'b00;
        vsync_sc_i        = 1'b1;
        ir_code_i         = '0;
        ir_code_cnt_i     = '0;
        pll_activeclock_i = 1'b0;
        report_test("status word");
    endtask

    task automatic cfg_and_pins_test();
        logic [3:0] pin_bits;
        // Jumpers move after the latch, the stored values must hold
        cfg_i = 2'b10;
        step(3);
        @(negedge clk27);
        check_equal(32'(controls_o[STAT_CFG0_BIT]), 32'd1, "cfg0 after jumper change");
        check_equal(32'(led_r_oe_o), 32'd0, "led_r_oe after jumper change");
        step(1);
        for (int k = 0; k < 4; k++) begin
            pin_bits = 4'b0001 << k;
            sys_ctrl_i[CTRL_HW_RESET_N_BIT] = pin_bits[0];
            sys_ctrl_i[CTRL_LCD_RS_BIT]     = pin_bits[1];
            sys_ctrl_i[CTRL_LCD_CS_N_BIT]   = pin_bits[2];
            sys_ctrl_i[CTRL_SD_SS_N_BIT]    = pin_bits[3];
            @(negedge clk27);
            check_equal(32'(hw_reset_n_o), 32'(pin_bits[0]), "hw_reset_n pin");
            check_equal(32'(lcd_rs_o), 32'(pin_bits[1]), "lcd_rs pin");
            check_equal(32'(lcd_cs_n_o), 32'(pin_bits[2]), "lcd_cs_n pin");
            check_equal(32'(sd_ss_n_o), 32'(pin_bits[3]), "sd_ss_n pin");
            step(1);
        end
        sys_ctrl_i[CTRL_HW_RESET_N_BIT] = 1'b1;
        sys_ctrl_i[CTRL_LCD_RS_BIT]     = 1'b0;
        sys_ctrl_i[CTRL_LCD_CS_N_BIT]   = 1'b1;
        sys_ctrl_i[CTRL_SD_SS_N_BIT]    = 1'b1;
        report_test("config and pins");
    endtask

    task automatic lock_warning_test();
        int waited;
        resync_strobe_i = 1'b1;
        step(1);
        resync_strobe_i = 1'b0;
        wait_for_led_r(1'b1, 5, waited);
        check_equal(32'(led_r_o), 32'd1, "led_r after resync strobe");
        check_equal(32'(led_g_o), 32'd0, "led_g during warning");
        wait_for_led_r(1'b0, 70, waited);
        check_equal(32'(led_r_o), 32'd0, "led_r clear after resync hold");
        check_equal(32'(waited >= 60 && waited <= 66), 32'd1,
                    $sformatf("resync hold of %0d cycles", waited));
        check_equal(32'(led_g_o), 32'd1, "led_g idle with zero IR code");
        step(1);
        ir_code_i = 16'h00a5;
        @(negedge clk27);
        check_equal(32'(led_g_o), 32'd0, "led_g with IR code present");
        step(1);
        ir_code_i = '0;
        // Scaler disabled, the strobe must not light the LED
        sys_ctrl_i[CTRL_ENABLE_SC_BIT] = 1'b0;
        resync_strobe_i = 1'b1;
        step(1);
        resync_strobe_i = 1'b0;
        repeat (10) begin
            @(negedge clk27);
            check_equal(32'(led_r_o), 32'd0, "led_r with scaler disabled");
        end
        step(1);
        sys_ctrl_i[CTRL_ENABLE_SC_BIT] = 1'b1;
        pll_locked_i = 1'b0;
        step(1);
        pll_locked_i = 1'b1;
        wait_for_led_r(1'b1, 3, waited);
        check_equal(32'(led_r_o), 32'd1, "led_r after PLL lock loss");
        wait_for_led_r(1'b0, 70, waited);
        check_equal(32'(led_r_o), 32'd0, "led_r clear after PLL hold");
        check_equal(32'(waited >= 60 && waited <= 66), 32'd1,
                    $sformatf("PLL warning hold of %0d cycles", waited));
        step(1);
        // No lock is expected while the PLL is held in reset
        pll_areset_i = 1'b1;
        pll_locked_i = 1'b0;
        repeat (5) begin
            @(negedge clk27);
            check_equal(32'(led_r_o), 32'd0, "led_r with PLL in reset");
        end
        step(1);
        pll_areset_i = 1'b0;
        pll_locked_i = 1'b1;
        report_test("lock warning");
    endtask

    task automatic clock_switch_test();
        logic [1:0] sw_in;
        logic       prev_sw;
        // Active clock 0 against scaler enabled
        prev_sw = 1'b1;
        for (int k = 0; k < 4; k++) begin
            sw_in = 2'(k);
            pll_activeclock_i              = sw_in[1];
            sys_ctrl_i[CTRL_ENABLE_SC_BIT] = sw_in[0];
            @(negedge clk27);
            check_equal(32'(pll_clkswitch_o), 32'(prev_sw), "clkswitch before edge");
            step(1);
            @(negedge clk27);
            prev_sw = sw_in[1] ^ sw_in[0];
            check_equal(32'(pll_clkswitch_o), 32'(prev_sw), "clkswitch after edge");
            step(1);
        end
        pll_activeclock_i              = 1'b0;
        sys_ctrl_i[CTRL_ENABLE_SC_BIT] = 1'b1;
        report_test("clock switch");
    endtask

    // Remote event starts the window, lit 100 ms before the limit, dark 100 ms after
    task automatic check_bl_window(input int limit_ms, input string what);
        toggle_remote();
        step((limit_ms - 100) * CLK_PER_MS);
        @(negedge clk27);
        check_equal(32'(lcd_bl_o), 32'd1, {what, " lit before limit"});
        step(200 * CLK_PER_MS);
        @(negedge clk27);
        check_equal(32'(lcd_bl_o), 32'd0, {what, " dark after limit"});
        step(1);
    endtask

    task automatic backlight_test();
        sys_ctrl_i[CTRL_BL_TIME_LSB +: 2] = 2'd1;
        check_bl_window(3000, "3 s timeout");
        toggle_remote();
        step(2000 * CLK_PER_MS);
        check_bl_window(3000, "3 s timeout after restart");
        sys_ctrl_i[CTRL_BL_ON_BIT] = 1'b0;
        toggle_remote();
        step(4);
        @(negedge clk27);
        check_equal(32'(lcd_bl_o), 32'd0, "backlight with bl_on low");
        step(1);
        sys_ctrl_i[CTRL_BL_ON_BIT] = 1'b1;
        @(negedge clk27);
        check_equal(32'(lcd_bl_o), 32'd1, "backlight with bl_on back high");
        step(1);
        sys_ctrl_i[CTRL_BL_TIME_LSB +: 2] = 2'd0;
        repeat (32) begin
            step(100 * CLK_PER_MS);
            @(negedge clk27);
            check_equal(32'(lcd_bl_o), 32'd1, "backlight with select 0");
        end
        step(1);
        sys_ctrl_i[CTRL_BL_TIME_LSB +: 2] = 2'd2;
        check_bl_window(10000, "10 s timeout");
        sys_ctrl_i[CTRL_BL_TIME_LSB +: 2] = 2'd3;
        check_bl_window(30000, "30 s timeout");
        report_test("backlight");
    endtask

    // Second power-on with jumper 1 fitted and jumper 0 open
    task automatic alt_jumper_test();
        int waited;
        cfg_i      = 2'b10;
        po_reset_n = 1'b0;
        step(8);
        po_reset_n = 1'b1;
        step(2);
        @(negedge clk27);
        check_equal(32'(led_r_oe_o), 32'd1, "led_r_oe with jumper 1 fitted");
        check_equal(32'(controls_o[STAT_CFG0_BIT]), 32'd0, "cfg0 with jumper 0 open");
        step(1);
        pll_locked_i = 1'b0;
        step(1);
        pll_locked_i = 1'b1;
        wait_for_led_r(1'b1, 3, waited);
        check_equal(32'(led_r_o), 32'd1, "led_r after PLL lock loss, jumper 1");
        check_equal(32'(led_g_o), 32'd1, "led_g during warning with jumper 1");
        wait_for_led_r(1'b0, 70, waited);
        check_equal(32'(led_r_o), 32'd0, "led_r clear after PLL hold, jumper 1");
        step(1);
        report_test("alternate jumper");
    endtask

    initial begin
        seed            = 32'h6856_0180;
        check_count     = 0;
        error_count     = 0;
        checks_at_start = 0;
        errors_at_start = 0;
        po_reset_n      = 1'b0;
        sys_ctrl_i      = '0;
        sys_ctrl_i[CTRL_HW_RESET_N_BIT] = 1'b1;
        sys_ctrl_i[CTRL_ENABLE_SC_BIT]  = 1'b1;
        sys_ctrl_i[CTRL_BL_ON_BIT]      = 1'b1;
        sys_ctrl_i[CTRL_LCD_CS_N_BIT]   = 1'b1;
        sys_ctrl_i[CTRL_SD_SS_N_BIT]    = 1'b1;
        btn_i             = 2'b00;
        cfg_i             = 2'b01;
        vsync_sc_i        = 1'b1;
        ir_code_i         = '0;
        ir_code_cnt_i     = '0;
        resync_strobe_i   = 1'b0;
        pll_areset_i      = 1'b0;
        pll_locked_i      = 1'b1;
        pll_activeclock_i = 1'b0;
        {r_i, g_i, b_i}    = '0;
        {de_i, hs_i, vs_i} = 3'b000;
        osd_enable_i      = 1'b0;
        osd_color_i       = '0;
        repeat (8) @(posedge clk27);
        #2;
        po_reset_n = 1'b1;
        step(2);
        osd_overlay_test();
        status_word_test();
        cfg_and_pins_test();
        lock_warning_test();
        clock_switch_test();
        backlight_test();
        alt_jumper_test();
        $display("Summary: %0d checks, %0d failed", check_count, error_count);
        if (error_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYC) begin
            @(posedge clk27);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYC);
        $display("Errors found");
        $finish;
    end

endmodule
